//--- Bender.yml
package:
  name: seven_seg_fun

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cmd_pkg.sv
      - rtl/disp_pkg.sv
      - rtl/button_events.sv
      - rtl/cmd_fifo.sv
      - rtl/segment_patterns.sv
      - rtl/animation_engine.sv
      - rtl/seven_seg_fun.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/seven_seg_fun_props.sv
      - tb/seven_seg_fun_tb.sv

//--- rtl/animation_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "seven_seg_cfg.svh"

module animation_engine
    import cmd_pkg::*;
    import disp_pkg::*;
#(
    parameter int tick_unit = `SSF_TICK_UNIT_DEFAULT
) (
    input  wire          clk,
    input  wire          reset,
    input  wire          head_valid,
    input  cmd_t         head,
    output logic         head_ready,
    output disp_status_t status
);
    localparam int TICK_W = $clog2(tick_unit + 1);

    logic [TICK_W-1:0] tick_cnt;   // Clocks within the current unit
    logic [4:0]        frame_cnt;  // Units elapsed in the current frame
    logic [4:0]        period_units;
    logic [5:0]        animation;
    logic [5:0]        digit;
    logic [5:0]        digit_limit;
    logic [6:0]        segments;
    logic              tick_end, period_end;
    logic              is_anim, accept;

    assign tick_end   = (tick_cnt == TICK_W'(tick_unit - 1));
    assign period_end = tick_end && (frame_cnt == period_units - 5'd1);
    assign is_anim    = (head.op == anim_next) || (head.op == anim_prev);

    // Speed changes wait for the frame boundary and block what sits behind them
    assign head_ready = head_valid && (is_anim || period_end);
    assign accept     = head_valid && head_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt  <= '0;
            frame_cnt <= '0;
        end else if (tick_end) begin
            tick_cnt  <= '0;
            frame_cnt <= period_end ? 5'd0 : frame_cnt + 5'd1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            animation    <= '0;
            digit        <= '0;
            period_units <= 5'(`SSF_PERIOD_INIT);
        end else begin
            if (period_end) begin
                digit <= (digit == digit_limit) ? 6'd0 : digit + 6'd1;
            end
            if (accept) begin
                case (head.op)
                    anim_next: begin
                        animation <= animation + 6'd1;  // 63 wraps to 0
                        digit     <= '0;
                    end
                    anim_prev: begin
                        animation <= animation - 6'd1;  // 0 wraps to 63
                        digit     <= '0;
                    end
                    speed_up: begin
                        if (period_units > 5'(`SSF_PERIOD_MIN)) begin
                            period_units <= period_units - 5'd1;
                        end
                    end
                    speed_down: begin
                        if (period_units < 5'(`SSF_PERIOD_MAX)) begin
                            period_units <= period_units + 5'd1;
                        end
                    end
                endcase
            end
        end
    end

    segment_patterns u_patterns (
        .animation   (animation),
        .digit       (digit),
        .segments    (segments),
        .digit_limit (digit_limit)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            status <= '{animation: '0, digit: '0,
                        period_units: 5'(`SSF_PERIOD_INIT), segments: '0};
        end else begin
            status <= '{animation: animation, digit: digit,
                        period_units: period_units, segments: segments};
        end
    end

endmodule

`default_nettype wire

//--- rtl/button_events.sv
`timescale 1ns/1ps
`default_nettype none

`include "seven_seg_cfg.svh"

module button_events
    import cmd_pkg::*;
(
    input  wire      clk,
    input  wire      reset,
    input  buttons_t buttons,
    output logic     cmd_valid,
    output cmd_t     cmd,
    input  wire      cmd_ready
);
    localparam int DB_MAX = `SSF_DEBOUNCE_CYCLES - 1;
    localparam int DB_W   = $clog2(`SSF_DEBOUNCE_CYCLES + 1);

    buttons_t        sync_q1, sync_q2;
    buttons_t        db_level;    // Debounced levels
    buttons_t        press;       // One-cycle rising event per button
    buttons_t        pending;
    buttons_t        clear_mask;
    logic [DB_W-1:0] db_cnt [4];
    logic [1:0]      pick;
    logic            pick_any;

    // Button index to command
    function automatic cmd_op_e op_for(input logic [1:0] b);
        case (b)
            2'd0:    return anim_next;
            2'd1:    return anim_prev;
            2'd2:    return speed_down;  // Slower button
            default: return speed_up;    // Faster button
        endcase
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= buttons;
            sync_q2 <= sync_q1;
        end
    end

    // Count samples that differ from the stable level, flip on the last one
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            db_level <= '0;
            for (int i = 0; i < 4; i++) db_cnt[i] <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (sync_q2[i] == db_level[i]) begin
                    db_cnt[i] <= '0;
                end else if (db_cnt[i] == DB_W'(DB_MAX)) begin
                    db_level[i] <= sync_q2[i];
                    db_cnt[i]   <= '0;
                end else begin
                    db_cnt[i] <= db_cnt[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            press[i] = sync_q2[i] && !db_level[i] && (db_cnt[i] == DB_W'(DB_MAX));
        end
        clear_mask = '0;
        if (cmd_valid && cmd_ready) clear_mask[cmd.src] = 1'b1;
        pick_any = |pending;
        pick = 2'd0;
        for (int i = 3; i >= 0; i--) begin  // Lowest index wins
            if (pending[i]) pick = 2'(i);
        end
    end

    // Pending stays set until the command is taken, so repeat presses merge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending   <= '0;
            cmd_valid <= 1'b0;
        end else begin
            pending <= (pending & ~clear_mask) | press;
            if (cmd_valid && cmd_ready) cmd_valid <= 1'b0;
            else if (!cmd_valid && pick_any) cmd_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!cmd_valid && pick_any) cmd <= '{op: op_for(pick), src: pick};
    end

endmodule

`default_nettype wire

//--- rtl/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "seven_seg_cfg.svh"

module cmd_fifo
    import cmd_pkg::*;
#(
    parameter int depth = `SSF_FIFO_DEPTH
) (
    input  wire  clk,
    input  wire  reset,
    input  wire  in_valid,
    input  cmd_t in_cmd,
    output logic in_ready,
    output logic out_valid,
    output cmd_t out_cmd,
    input  wire  out_ready
);
    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    cmd_t             mem [depth];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write, do_read;

    assign in_ready  = (count != CNT_W'(depth));  // Not full
    assign out_valid = (count != '0);
    assign out_cmd   = mem[rd_ptr];
    assign do_write  = in_valid && in_ready;
    assign do_read   = out_valid && out_ready;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(depth - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (do_write) mem[wr_ptr] <= in_cmd;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) wr_ptr <= ptr_inc(wr_ptr);
            if (do_read) rd_ptr <= ptr_inc(rd_ptr);
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/cmd_pkg.sv
`default_nettype none

package cmd_pkg;

    // Commands on the stream from button_events to animation_engine
    // speed_up shortens the period, speed_down lengthens it
    typedef enum logic [1:0] {
        anim_next  = 2'd0,
        anim_prev  = 2'd1,
        speed_up   = 2'd2,
        speed_down = 2'd3
    } cmd_op_e;

    typedef struct packed {
        cmd_op_e    op;
        logic [1:0] src;  // Button that raised the command
    } cmd_t;

    // Raw button levels
    // bit 0 next, bit 1 previous, bit 2 slower, bit 3 faster
    typedef logic [3:0] buttons_t;

endpackage

`default_nettype wire

//--- rtl/disp_pkg.sv
`default_nettype none

package disp_pkg;

    // Pattern family, selected by animation[1:0]
    typedef enum logic [1:0] {
        decimal = 2'd0,  // Glyphs 0 to 9
        hex     = 2'd1,  // Glyphs 0 to F
        spin    = 2'd2,  // Single segment walking a to f
        fill    = 2'd3   // Segments a to g switched on one by one
    } family_e;

    // Registered display state driven out of the top
    // Segment bits are {g, f, e, d, c, b, a}, active high
    typedef struct packed {
        logic [5:0] animation;
        logic [5:0] digit;
        logic [4:0] period_units;
        logic [6:0] segments;
    } disp_status_t;

endpackage

`default_nettype wire

//--- rtl/segment_patterns.sv
`timescale 1ns/1ps
`default_nettype none

module segment_patterns
    import disp_pkg::*;
(
    input  wire [5:0]  animation,
    input  wire [5:0]  digit,
    output logic [6:0] segments,
    output logic [5:0] digit_limit
);
    family_e    family;
    logic [6:0] raw;
    logic [7:0] fill_bits;

    // Glyph table, bits {g, f, e, d, c, b, a}
    function automatic logic [6:0] glyph(input logic [3:0] d);
        case (d)
            4'h0:    return 7'b0111111;
            4'h1:    return 7'b0000110;
            4'h2:    return 7'b1011011;
            4'h3:    return 7'b1001111;
            4'h4:    return 7'b1100110;
            4'h5:    return 7'b1101101;
            4'h6:    return 7'b1111101;
            4'h7:    return 7'b0000111;
            4'h8:    return 7'b1111111;
            4'h9:    return 7'b1101111;
            4'hA:    return 7'b1110111;
            4'hB:    return 7'b1111100;
            4'hC:    return 7'b0111001;
            4'hD:    return 7'b1011110;
            4'hE:    return 7'b1111001;
            default: return 7'b1110001;  // F
        endcase
    endfunction

    assign family    = family_e'(animation[1:0]);
    assign fill_bits = (8'd1 << digit[2:0]) - 8'd1;  // Digit 0 gives blank

    always_comb begin
        case (family)
            decimal: begin
                raw         = glyph(digit[3:0]);
                digit_limit = 6'd9;
            end
            hex: begin
                raw         = glyph(digit[3:0]);
                digit_limit = 6'd15;
            end
            spin: begin
                raw         = 7'(7'd1 << digit[2:0]);
                digit_limit = 6'd5;
            end
            default: begin  // fill
                raw         = fill_bits[6:0];
                digit_limit = 6'd7;
            end
        endcase
        segments = animation[2] ? ~raw : raw;  // Inverted variants
    end

endmodule

`default_nettype wire

//--- rtl/seven_seg_cfg.svh
`ifndef SEVEN_SEG_CFG_SVH
`define SEVEN_SEG_CFG_SVH

// Debounce: consecutive equal samples before a level counts as stable
`define SSF_DEBOUNCE_CYCLES 4

// Entries in the command buffer between producer and consumer
`define SSF_FIFO_DEPTH 4

// Step period, counted in units of SSF_TICK_UNIT_DEFAULT clocks
`define SSF_PERIOD_INIT 10
`define SSF_PERIOD_MIN 1
`define SSF_PERIOD_MAX 30  // Must fit the 5-bit period_units field

// Clocks per period unit, 10 ms at 10 MHz
`define SSF_TICK_UNIT_DEFAULT 100000

`endif

//--- rtl/seven_seg_fun.sv
`timescale 1ns/1ps
`default_nettype none

`include "seven_seg_cfg.svh"

module seven_seg_fun
    import cmd_pkg::*;
    import disp_pkg::*;
#(
    parameter int tick_unit = `SSF_TICK_UNIT_DEFAULT
) (
    input  wire          clk,
    input  wire          reset,
    input  buttons_t     buttons,
    output disp_status_t status
);
    logic cmd_valid, cmd_ready;
    cmd_t cmd;
    logic head_valid, head_ready;
    cmd_t head;

    button_events u_events (
        .clk       (clk),
        .reset     (reset),
        .buttons   (buttons),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready)
    );

    cmd_fifo #(.depth(`SSF_FIFO_DEPTH)) u_fifo (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (cmd_valid),
        .in_cmd    (cmd),
        .in_ready  (cmd_ready),
        .out_valid (head_valid),
        .out_cmd   (head),
        .out_ready (head_ready)
    );

    animation_engine #(.tick_unit(tick_unit)) u_engine (
        .clk        (clk),
        .reset      (reset),
        .head_valid (head_valid),
        .head       (head),
        .head_ready (head_ready),
        .status     (status)
    );

endmodule

`default_nettype wire

//--- seven_seg_fun.f
+incdir+rtl
rtl/cmd_pkg.sv
rtl/disp_pkg.sv
rtl/button_events.sv
rtl/cmd_fifo.sv
rtl/segment_patterns.sv
rtl/animation_engine.sv
rtl/seven_seg_fun.sv
tb/seven_seg_fun_props.sv
tb/seven_seg_fun_tb.sv

//--- tb/seven_seg_fun_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "seven_seg_cfg.svh"

module seven_seg_fun_props
    import cmd_pkg::*;
(
    input wire       clk,
    input wire       reset,
    input wire       head_valid,
    input cmd_t      head,
    input wire       head_ready,
    input wire [4:0] period_units,
    input wire [5:0] digit,
    input wire [5:0] digit_limit
);
    int fail_count = 0;  // Failed assertions so far

    // A stalled head keeps its command until the engine takes it
    head_stable: assert property (@(posedge clk) disable iff (reset)
        head_valid && !head_ready |=> head_valid && $stable(head))
        else begin
            fail_count++;
            $error("command at the FIFO head changed while stalled");
        end

    period_in_range: assert property (@(posedge clk) disable iff (reset)
        period_units >= 5'(`SSF_PERIOD_MIN) && period_units <= 5'(`SSF_PERIOD_MAX))
        else begin
            fail_count++;
            $error("period_units 0x%h left its range", period_units);
        end

    digit_in_range: assert property (@(posedge clk) disable iff (reset)
        digit <= digit_limit)  // Limit follows the current animation
        else begin
            fail_count++;
            $error("digit 0x%h above limit 0x%h", digit, digit_limit);
        end

endmodule

bind animation_engine seven_seg_fun_props u_props (
    .clk          (clk),
    .reset        (reset),
    .head_valid   (head_valid),
    .head         (head),
    .head_ready   (head_ready),
    .period_units (period_units),
    .digit        (digit),
    .digit_limit  (digit_limit)
);

`default_nettype wire

//--- tb/seven_seg_fun_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "seven_seg_cfg.svh"

module seven_seg_fun_tb
    import cmd_pkg::*;
    import disp_pkg::*;
();
    typedef struct packed {
        logic [6:0] segments;
        logic [5:0] limit;
    } pattern_ref_t;

    localparam int HOLD = 2 * `SSF_DEBOUNCE_CYCLES;  // Press and release length
    // Glyphs F down to 0, seven bits each as {g, f, e, d, c, b, a}
    localparam logic [16*7-1:0] GLYPHS = {7'h71, 7'h79, 7'h5E, 7'h39, 7'h7C, 7'h77,
        7'h6F, 7'h7F, 7'h07, 7'h7D, 7'h6D, 7'h66, 7'h4F, 7'h5B, 7'h06, 7'h3F};

    logic         clk, reset, monitor_on;
    buttons_t     buttons;
    disp_status_t status, last_status;
    logic [31:0]  rng;
    logic [5:0]   exp_anim;    // Model of the animation index
    logic [4:0]   exp_period;  // Model of period_units
    int           errors, checks, test_start;

    seven_seg_fun #(.tick_unit(4)) u_dut (
        .clk     (clk),
        .reset   (reset),
        .buttons (buttons),
        .status  (status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic pattern_ref_t ref_pattern(input logic [5:0] anim, input logic [5:0] dig);
        pattern_ref_t r;
        r.segments = '0;
        case (anim[1:0])
            2'd0: r.limit = 6'd9;
            2'd1: r.limit = 6'd15;
            2'd2: r.limit = 6'd5;
            default: r.limit = 6'd7;
        endcase
        if (anim[1] == 1'b0) r.segments = GLYPHS[dig[3:0]*7 +: 7];
        else if (anim[0] == 1'b0) r.segments[dig[2:0]] = 1'b1;  // Spin, single segment
        for (int i = 0; i < 7; i++) begin
            if (anim[1:0] == 2'd3 && i < dig) r.segments[i] = 1'b1;
        end
        if (anim[2]) r.segments = ~r.segments;
        return r;
    endfunction

    task automatic check_status(input disp_status_t got, input disp_status_t exp);
        checks++;
        if (got.animation !== exp.animation) begin
            errors++;
            $display("mismatch status.animation: got 0x%h expected 0x%h",
                     got.animation, exp.animation);
        end
        if (got.digit !== exp.digit) begin
            errors++;
            $display("mismatch status.digit: got 0x%h expected 0x%h", got.digit, exp.digit);
        end
        if (got.period_units !== exp.period_units) begin
            errors++;
            $display("mismatch status.period_units: got 0x%h expected 0x%h",
                     got.period_units, exp.period_units);
        end
    endtask

    task automatic check_segments(input logic [6:0] got, input logic [6:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch status.segments: got 0x%h expected 0x%h", got, exp);
        end
    endtask

    // Every status change must show the pattern for its own animation and digit
    always @(negedge clk) begin
        pattern_ref_t pat;
        if (monitor_on && status !== last_status) begin
            pat = ref_pattern(status.animation, status.digit);
            check_segments(status.segments, pat.segments);
        end
        last_status = status;
    end

    // Press and release one button and follow the model until the step shows
    task automatic press(input int btn);
        logic [5:0] start_anim;
        logic       seen;
        int         cyc;
        start_anim = status.animation;
        seen = (btn >= 2);  // Speed presses show no animation step
        if (btn == 0) exp_anim = exp_anim + 6'd1;
        if (btn == 1) exp_anim = exp_anim - 6'd1;
        if (btn == 2 && exp_period < 5'(`SSF_PERIOD_MAX)) exp_period = exp_period + 5'd1;
        if (btn == 3 && exp_period > 5'(`SSF_PERIOD_MIN)) exp_period = exp_period - 5'd1;
        for (cyc = 0; cyc < 400 && !(seen && cyc >= 2 * HOLD); cyc++) begin
            @(posedge clk);
            #1 buttons[btn] = (cyc < HOLD);
            @(negedge clk);
            if (!seen && status.animation != start_anim) begin
                seen = 1'b1;
                check_status(status, '{animation: exp_anim, digit: 6'd0,
                                       period_units: exp_period, segments: 7'd0});
            end
        end
        if (!seen) begin
            errors++;
            $display("timeout, button %0d press never reached the animation", btn);
        end
    endtask

    task automatic hold_steady(input int cycles);
        checks++;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (status.animation != exp_anim) begin
                errors++;
                $display("mismatch status.animation: got 0x%h expected 0x%h",
                         status.animation, exp_anim);
                return;
            end
        end
    endtask

    task automatic goto_anim(input logic [5:0] target);
        logic [5:0] ahead;
        for (int n = 0; n < 64 && exp_anim != target; n++) begin
            ahead = target - exp_anim;
            press((ahead < 6'd32) ? 0 : 1);
        end
    endtask

    // Step the digit through a full cycle including the wrap
    task automatic run_frames(input logic [5:0] target);
        logic [5:0]   digit_now, next_digit, limit;
        pattern_ref_t pat;
        int           cyc;
        goto_anim(target);
        pat = ref_pattern(target, 6'd0);
        limit = pat.limit;
        digit_now = status.digit;
        for (int step = 0; step <= limit; step++) begin
            next_digit = (digit_now == limit) ? 6'd0 : digit_now + 6'd1;
            for (cyc = 0; cyc < 200 && status.digit == digit_now; cyc++) @(negedge clk);
            if (status.digit == digit_now) begin
                errors++;
                $display("timeout, digit stuck at 0x%h on animation 0x%h", digit_now, target);
                return;
            end
            check_status(status, '{animation: exp_anim, digit: next_digit,
                                   period_units: exp_period, segments: 7'd0});
            pat = ref_pattern(target, next_digit);
            check_segments(status.segments, pat.segments);
            digit_now = status.digit;
        end
    endtask

    task automatic report(input string name);
        $display("test %-10s %s, %0d errors", name,
                 (errors == test_start) ? "ok" : "failing", errors - test_start);
        test_start = errors;
    endtask

    initial begin
        int glitch, gbtn;
        rng = 32'd95;
        {errors, checks, test_start} = '0;
        monitor_on = 1'b0;
        buttons = '0;
        reset = 1'b1;
        exp_anim = '0;
        exp_period = 5'(`SSF_PERIOD_INIT);
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        @(posedge clk);
        @(negedge clk);  // Status follows the state by one cycle
        check_status(status, '{animation: 6'd0, digit: 6'd0,
                               period_units: 5'(`SSF_PERIOD_INIT), segments: 7'd0});
        check_segments(status.segments, GLYPHS[6:0]);
        monitor_on = 1'b1;
        report("reset");

        for (int i = 0; i < 8; i++) begin
            glitch = 1 + int'(next_random() % 3);  // Always below the debounce length
            gbtn = int'(next_random() % 2);
            for (int c = 0; c < glitch + 3; c++) begin
                @(posedge clk);
                #1 buttons[gbtn] = (c < glitch);
            end
        end
        hold_steady(20);
        press(0);
        hold_steady(40);
        report("debounce");

        press(1);  // Down to 0, then wrap to 63 and back
        press(1);
        press(0);
        for (int i = 0; i < 24; i++) press(int'(next_random() % 2));
        report("stepping");

        for (int i = 0; i < 12; i++) begin
            press(3);
            press(0);  // Queued behind the speed command
        end
        for (int i = 0; i < 32; i++) begin
            press(2);
            press(int'(next_random() % 2));
        end
        report("speed");

        for (int a = 0; a < 8; a++) run_frames(6'(a));
        report("frames");

        errors += u_dut.u_engine.u_props.fail_count;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
